// ==== dcm_macros.svh ====
// ############################
// Widths, FIFO depth and register
// word addresses for the duty meter
// ############################
`ifndef DCM_MACROS_SVH
`define DCM_MACROS_SVH

// Record field widths
`define DCM_DUTY_W      7
`define DCM_PERIOD_W    16

`define DCM_FIFO_DEPTH  8
`define DCM_LEVEL_W     4   // Holds 0 to DCM_FIFO_DEPTH

// Wishbone word addresses
`define DCM_ADR_DATA    2'd0
`define DCM_ADR_STATUS  2'd1
`define DCM_ADR_CTRL    2'd2

`endif

// ==== dcm_pkg.sv ====
// ############################
// Record and register address types
// ############################
`include "dcm_macros.svh"

package dcm_pkg;

    // One measured period
    typedef struct packed {
        logic [`DCM_DUTY_W-1:0]   duty;     // 0 to 127
        logic [`DCM_PERIOD_W-1:0] period;   // In clock cycles
    } meas_rec_t;

    // Register words seen on the bus
    typedef enum logic [1:0] {
        REG_DATA   = `DCM_ADR_DATA,
        REG_STATUS = `DCM_ADR_STATUS,
        REG_CTRL   = `DCM_ADR_CTRL
    } reg_addr_t;

endpackage

// ==== meas_fifo_if.sv ====
// ############################
// FIFO read side to bus port
// ############################
`timescale 1ns/10ps
`include "dcm_macros.svh"

interface meas_fifo_if;
    import dcm_pkg::*;

    meas_rec_t               head;      // Oldest record
    logic                    empty;
    logic [`DCM_LEVEL_W-1:0] level;
    logic                    overflow;  // Sticky
    logic                    pop;
    logic                    clr_ovf;

    modport fifo_side (
        output head, empty, level, overflow,
        input  pop, clr_ovf
    );

    modport port_side (
        input  head, empty, level, overflow,
        output pop, clr_ovf
    );

endinterface

// ==== duty_meter.sv ====
// ############################
// Input sync, edge detect, period
// and high counters, duty calc
// ############################
`timescale 1ns/10ps
`include "dcm_macros.svh"

module duty_meter (
    input  logic               clk,
    input  logic               rst,
    input  logic               sig_in,
    input  logic               enable,
    output logic               push,
    output dcm_pkg::meas_rec_t rec
);
    localparam int PW = `DCM_PERIOD_W;
    localparam int DW = `DCM_DUTY_W;
    localparam int QW = PW + DW;
    localparam logic [PW-1:0] CNT_MAX  = '1;
    localparam logic [QW-1:0] DUTY_MAX = QW'((1 << DW) - 1);

    logic          sig_s1;
    logic          sig_s2;
    logic          sig_d;      // Delayed copy for edge detect
    logic          rise;
    logic          armed;      // A period is open
    logic [PW-1:0] period_cnt;
    logic [PW-1:0] high_cnt;
    logic [QW-1:0] quot;
    logic [DW-1:0] duty;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sig_s1 <= 1'b0;
            sig_s2 <= 1'b0;
            sig_d  <= 1'b0;
        end else begin
            sig_s1 <= sig_in;
            sig_s2 <= sig_s1;
            sig_d  <= sig_s2;
        end
    end

    assign rise = sig_s2 & ~sig_d;

    // Quotient high * 128 / period
    always_comb begin
        if (period_cnt == '0)
            quot = '0;      // No open period
        else
            quot = {high_cnt, {DW{1'b0}}} / {{DW{1'b0}}, period_cnt};
    end

    assign duty = (quot > DUTY_MAX) ? DUTY_MAX[DW-1:0] : quot[DW-1:0];  // Full high

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            armed      <= 1'b0;
            push       <= 1'b0;
            period_cnt <= '0;
            high_cnt   <= '0;
        end else begin
            push <= 1'b0;
            if (!enable) begin
                // Wait for a fresh opening edge
                armed      <= 1'b0;
                period_cnt <= '0;
                high_cnt   <= '0;
            end else if (rise) begin
                armed      <= 1'b1;
                push       <= armed;       // First edge only opens
                period_cnt <= PW'(1);
                high_cnt   <= PW'(1);      // Input is high in the edge cycle
            end else if (armed) begin
                if (period_cnt != CNT_MAX)
                    period_cnt <= period_cnt + 1'b1;
                if (sig_s2 && high_cnt != CNT_MAX)
                    high_cnt <= high_cnt + 1'b1;
            end
        end
    end

    // Record capture on a closing edge
    always_ff @(posedge clk) begin
        if (enable && rise && armed) begin
            rec.duty   <= duty;
            rec.period <= period_cnt;
        end
    end

endmodule

// ==== meas_fifo.sv ====
// ############################
// Record FIFO, level and overflow
// ############################
`timescale 1ns/10ps
`include "dcm_macros.svh"

module meas_fifo #(
    parameter int DEPTH = `DCM_FIFO_DEPTH
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               push,
    input  dcm_pkg::meas_rec_t rec,
    meas_fifo_if.fifo_side     rd
);
    import dcm_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [`DCM_LEVEL_W-1:0] FULL_LVL = DEPTH[`DCM_LEVEL_W-1:0];

    meas_rec_t               mem [DEPTH];
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    logic [`DCM_LEVEL_W-1:0] count;
    logic                    ovf;
    logic                    full;
    logic                    do_push;
    logic                    do_pop;

    assign full    = (count == FULL_LVL);
    assign do_push = push && !full;
    assign do_pop  = rd.pop && !rd.empty;

    assign rd.empty    = (count == '0);
    assign rd.level    = count;
    assign rd.overflow = ovf;
    assign rd.head     = mem[rd_ptr];   // Oldest entry

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= rec;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            ovf    <= 1'b0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;   // Wraps at DEPTH
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // A drop in the clear cycle keeps the flag set
            if (push && full)
                ovf <= 1'b1;
            else if (rd.clr_ovf)
                ovf <= 1'b0;
        end
    end

endmodule

// ==== wb_meas_port.sv ====
// ############################
// Wishbone slave, data/status/ctrl
// ############################
`timescale 1ns/10ps

module wb_meas_port (
    input  logic           clk,
    input  logic           rst,
    input  logic           wb_cyc,
    input  logic           wb_stb,
    input  logic           wb_we,
    input  logic [1:0]     wb_adr,
    input  logic [31:0]    wb_dat_w,
    output logic [31:0]    wb_dat_r,
    output logic           wb_ack,
    output logic           enable,
    meas_fifo_if.port_side rd
);
    import dcm_pkg::*;

    reg_addr_t   adr;
    logic        req;        // Request not yet acked
    logic        pop_q;
    logic        clr_q;
    logic [31:0] rdata;

    assign adr = reg_addr_t'(wb_adr);
    assign req = wb_cyc && wb_stb && !wb_ack;

    // Read mux
    always_comb begin
        rdata = '0;
        case (adr)
            REG_DATA: begin
                if (!rd.empty) begin
                    rdata[31:16] = rd.head.period;
                    rdata[15]    = 1'b1;          // Valid
                    rdata[6:0]   = rd.head.duty;
                end
            end
            REG_STATUS: begin
                rdata[3:0] = rd.level;
                rdata[8]   = rd.overflow;
                rdata[9]   = rd.empty;
            end
            REG_CTRL: rdata[0] = enable;
            default:  rdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wb_ack <= 1'b0;
            pop_q  <= 1'b0;
            clr_q  <= 1'b0;
            enable <= 1'b0;
        end else begin
            wb_ack <= req;
            // Both pulses line up with ack
            pop_q  <= req && !wb_we && (adr == REG_DATA) && !rd.empty;
            clr_q  <= req && wb_we && (adr == REG_STATUS) && wb_dat_w[8];
            if (req && wb_we && (adr == REG_CTRL))
                enable <= wb_dat_w[0];
        end
    end

    always_ff @(posedge clk) begin
        if (req && !wb_we)
            wb_dat_r <= rdata;
    end

    assign rd.pop     = pop_q;
    assign rd.clr_ovf = clr_q;

endmodule

// ==== dcm_top.sv ====
// ############################
// Duty cycle meter top level
// ############################
`timescale 1ns/10ps
`include "dcm_macros.svh"

module dcm_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        sig_in,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [1:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack
);
    import dcm_pkg::*;

    logic      push;
    logic      enable;     // From CTRL bit 0
    meas_rec_t rec;

    meas_fifo_if fifo_rd ();

    duty_meter u_meter (
        .clk    (clk),
        .rst    (rst),
        .sig_in (sig_in),
        .enable (enable),
        .push   (push),
        .rec    (rec)
    );

    meas_fifo #(
        .DEPTH (`DCM_FIFO_DEPTH)
    ) u_fifo (
        .clk  (clk),
        .rst  (rst),
        .push (push),
        .rec  (rec),
        .rd   (fifo_rd.fifo_side)
    );

    wb_meas_port u_port (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .enable   (enable),
        .rd       (fifo_rd.port_side)
    );

endmodule

// ==== tb_clkgen.sv ====
// ##############################
// Testbench clock and reset
// ##############################
`timescale 1ns/10ps

module tb_clkgen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period
    end

    initial begin
        rst = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b1;
    end

endmodule

// ==== tb_dcm_top.sv ====
// ##############################
// Directed tests, PWM source, bus
// tasks, compare tasks, watchdog
// ##############################
`timescale 1ns/10ps
`include "dcm_macros.svh"

module tb_dcm_top;
    import dcm_pkg::*;

    // Summed PWM cycles of all tests
    localparam int PWM_CYCLES = 150 + 300 + (6 * 300 + 16) + 11 * 40 + 246;
    localparam int TIMEOUT_NS = (PWM_CYCLES + 1500) * 10;

    logic        clk;
    logic        rst;
    logic        sig_in;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [1:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;

    tb_clkgen clkgen0 (.clk(clk), .rst(rst));

    dcm_top dut0 (
        .clk(clk), .rst(rst), .sig_in(sig_in),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp)
            abort_run($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_rec(input string name, input meas_rec_t exp, input meas_rec_t act);
        if (act !== exp)
            abort_run($sformatf(
                "FAILED %s: expected period %0d duty %0d, actual period %0d duty %0d",
                name, exp.period, exp.duty, act.period, act.duty));
    endtask

    // Classic single cycle sampled on the falling edge
    task automatic wb_access(input reg_addr_t adr, input logic we, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int waited;
        waited = 0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdat;
        do begin
            @(negedge clk);
            waited++;
            if (waited > 16)
                abort_run("No ack from the DUT within 16 cycles");
        end while (wb_ack !== 1'b1);
        rdat = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(negedge clk);
        if (wb_ack !== 1'b0)
            abort_run("Ack from the DUT stayed high for more than one cycle");
    endtask

    task automatic wb_read(input reg_addr_t adr, output logic [31:0] rdat);
        wb_access(adr, 1'b0, 32'h0, rdat);
    endtask

    task automatic wb_write(input reg_addr_t adr, input logic [31:0] wdat);
        logic [31:0] unused;
        wb_access(adr, 1'b1, wdat, unused);
    endtask

    // Back to back periods with one level per rising edge
    task automatic drive_pwm(input int period, input int high, input int n);
        repeat (n) begin
            for (int c = 0; c < period; c++) begin
                @(posedge clk);
                sig_in <= (c < high);
            end
        end
    endtask

    task automatic restart_meter();
        wb_write(REG_CTRL, 32'h0);   // Drops any open period
        wb_write(REG_CTRL, 32'h1);
    endtask

    task automatic expect_status(input string name, input int lvl, input logic ovf);
        logic [31:0] w;
        wb_read(REG_STATUS, w);
        check_word(name, {22'b0, lvl == 0, ovf, 4'b0, 4'(lvl)}, w);
    endtask

    task automatic expect_record(input string name, input int period, input int high);
        meas_rec_t   exp;
        meas_rec_t   act;
        logic [31:0] w;
        int          q;
        q          = high * 128 / period;
        exp.period = 16'(period);
        exp.duty   = 7'((q > 127) ? 127 : q);
        wb_read(REG_DATA, w);
        check_word($sformatf("%s flags", name), 32'h0000_8000, w & 32'h0000_ff80);
        act.period = w[31:16];
        act.duty   = w[6:0];
        check_rec(name, exp, act);
    endtask

    task automatic test_reset_disabled();
        logic [31:0] w;
        expect_status("reset status", 0, 1'b0);
        wb_read(REG_CTRL, w);
        check_word("reset ctrl", 32'h0, w);
        drive_pwm(50, 10, 3);
        wb_read(REG_DATA, w);
        check_word("disabled data", 32'h0, w);
        expect_status("disabled status", 0, 1'b0);
    endtask

    task automatic test_fixed_duty();
        logic [31:0] w;
        restart_meter();
        wb_read(REG_CTRL, w);
        check_word("enabled ctrl", 32'h1, w);
        drive_pwm(100, 25, 3);   // First edge only opens
        expect_status("fixed level", 2, 1'b0);
        repeat (2) expect_record("fixed record", 100, 25);
        expect_status("fixed drained", 0, 1'b0);
    endtask

    task automatic test_random_shapes();
        int per_q[$];
        int high_q[$];
        int p;
        int h;
        restart_meter();
        for (int i = 0; i < 6; i++) begin
            p = 4 + int'($urandom % 297);
            h = 1 + int'($urandom % (p - 1));
            per_q.push_back(p);
            high_q.push_back(h);
            drive_pwm(p, h, 1);
        end
        drive_pwm(16, 1, 1);     // Closes the last shape
        expect_status("random level", 6, 1'b0);
        foreach (per_q[i])
            expect_record($sformatf("random record %0d", i), per_q[i], high_q[i]);
    endtask

    task automatic test_overflow();
        restart_meter();
        for (int i = 0; i < `DCM_FIFO_DEPTH + 3; i++)
            drive_pwm(40, 4 + 2 * i, 1);   // Ten records of distinct shapes
        expect_status("overflow full", `DCM_FIFO_DEPTH, 1'b1);
        for (int i = 0; i < `DCM_FIFO_DEPTH; i++)
            expect_record($sformatf("overflow record %0d", i), 40, 4 + 2 * i);
        expect_status("overflow drained", 0, 1'b1);
        wb_write(REG_STATUS, 32'h0000_0100);
        expect_status("overflow cleared", 0, 1'b0);
    endtask

    task automatic test_reenable();
        restart_meter();
        drive_pwm(60, 30, 1);    // Period left open
        wb_write(REG_CTRL, 32'h0);
        wb_write(REG_CTRL, 32'h1);
        drive_pwm(80, 20, 1);
        drive_pwm(90, 45, 1);
        drive_pwm(16, 1, 1);
        expect_status("reenable level", 2, 1'b0);
        expect_record("reenable first", 80, 20);
        expect_record("reenable second", 90, 45);
    endtask

    initial begin
        sig_in   = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 2'd0;
        wb_dat_w = 32'h0;
        void'($urandom(32'h92f2_710e));
        wait (rst === 1'b1);
        test_reset_disabled();
        test_fixed_duty();
        test_random_shapes();
        test_overflow();
        test_reenable();
        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        abort_run("Watchdog expired before the tests finished");
    end

endmodule

// ==== flist.f ====
+incdir+.
dcm_pkg.sv
meas_fifo_if.sv
duty_meter.sv
meas_fifo.sv
wb_meas_port.sv
dcm_top.sv
tb_clkgen.sv
tb_dcm_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the duty meter testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/10ps -f flist.f \
    --top-module tb_dcm_top -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_dcm_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1
